// File: common/pong_pkg.sv
`default_nettype none

package pong_pkg;

    // ball as it moves on the local screen and over the link
    typedef struct packed {
        logic [9:0]        x;
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic [1:0]        grav;   // gravity phase, vy steps on every fourth move
        logic              fast;   // set when the move period is the base period
    } ball_state_t;

    typedef struct packed {
        ball_state_t ball;
        logic        win;
    } handoff_t;

    // order matters, status_led is one-hot on this encoding
    typedef enum logic [2:0] {
        idle,
        wait_link,
        win_flag,
        running_right,
        running_left,
        stop,
        send_ball
    } game_state_t;

    // link register map, byte addresses
    localparam logic [7:0] addr_in_y_hi   = 8'h00;   // bits 7:6 carry y[9:8]
    localparam logic [7:0] addr_in_y_lo   = 8'h04;
    localparam logic [7:0] addr_in_vy     = 8'h08;
    localparam logic [7:0] addr_in_grav   = 8'h0C;
    localparam logic [7:0] addr_in_speed  = 8'h10;
    localparam logic [7:0] addr_in_win    = 8'h14;
    localparam logic [7:0] addr_commit    = 8'h18;
    localparam logic [7:0] addr_ack       = 8'h1C;
    localparam logic [7:0] addr_out_y_hi  = 8'h20;
    localparam logic [7:0] addr_out_y_lo  = 8'h24;
    localparam logic [7:0] addr_out_vy    = 8'h28;
    localparam logic [7:0] addr_out_grav  = 8'h2C;
    localparam logic [7:0] addr_out_speed = 8'h30;
    localparam logic [7:0] addr_status    = 8'h34;

    // game geometry
    localparam logic [9:0] serve_y     = 10'd220;
    localparam logic [9:0] return_x    = 10'd620;
    localparam logic [9:0] step_x      = 10'd10;
    localparam logic [9:0] edge_margin = 10'd20;

endpackage

`default_nettype wire

// File: game/game_controller.sv
`timescale 1ns/1ps
`default_nettype none

module game_controller
    import pong_pkg::*;
#(
    parameter int STEP_BASE = 270000
) (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic        game_start,
    input  logic        collision,
    input  logic [9:0]  est_speed,
    input  handoff_t    incoming,
    input  logic        slave_done,
    input  logic        master_done,
    output ball_state_t ball,
    output logic        moving_left,
    output logic        moving_right,
    output logic        game_over,
    output logic        you_win,
    output logic        send_trigger,
    output logic        clear_done,
    output logic [7:0]  status_led
);

    localparam int pw = $clog2(STEP_BASE + 1);
    localparam logic [pw-1:0] period_base = pw'(STEP_BASE);
    localparam logic [pw-1:0] period_half = pw'(STEP_BASE / 2);
    localparam ball_state_t serve_ball = '{
        x: 10'd0, y: serve_y, vy: -8'sd3, grav: 2'd0, fast: 1'b1
    };

    game_state_t   state, state_next;
    ball_state_t   ball_next, loaded_ball;
    logic [pw-1:0] move_cnt, move_cnt_next;
    logic [pw-1:0] period, period_next, loaded_period;
    logic          game_over_next, you_win_next, send_trigger_next, clear_done_next;
    logic [9:0]    x_edge, x_return, y_max, safe_speed;
    logic          move_due;

    // one move in either direction, with gravity, clamp and bounce
    function automatic ball_state_t move_ball(input ball_state_t b, input logic left,
                                              input logic [9:0] ymax);
        ball_state_t       n;
        logic signed [11:0] y_sum;
        n = b;
        if (left)
            n.x = (b.x > step_x) ? b.x - step_x : 10'd0;
        else
            n.x = b.x + step_x;
        if (b.grav == 2'd3) begin
            n.vy   = b.vy + 8'sd1;
            n.grav = 2'd0;
        end else begin
            n.grav = b.grav + 2'd1;
        end
        y_sum = $signed({2'b00, b.y}) + $signed({{4{b.vy[7]}}, b.vy});  // old vy
        if (y_sum >= $signed({2'b00, ymax})) begin
            n.y  = ymax;
            n.vy = -n.vy;
        end else if (y_sum <= 12'sd0) begin
            n.y  = 10'd0;
            n.vy = -n.vy;
        end else begin
            n.y = y_sum[9:0];
        end
        return n;
    endfunction

    assign y_max      = upscale ? 10'd479 : 10'd239;
    assign x_edge     = (upscale ? 10'd640 : 10'd320) - edge_margin;
    assign x_return   = upscale ? return_x : return_x - 10'd320;
    assign safe_speed = (est_speed == 10'd0) ? 10'd1 : est_speed;
    assign move_due   = move_cnt >= period;

    assign moving_left  = (state == running_left);
    assign moving_right = (state == running_right);
    assign status_led   = 8'd1 << state;

    // ball handed over by the partner, enters at the right side
    always_comb begin
        loaded_ball   = incoming.ball;
        loaded_ball.x = x_return;
    end
    assign loaded_period = incoming.ball.fast ? period_base : period_half;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state        <= idle;
            ball         <= serve_ball;
            move_cnt     <= '0;
            period       <= period_base;
            game_over    <= 1'b0;
            you_win      <= 1'b0;
            send_trigger <= 1'b0;
            clear_done   <= 1'b0;
        end else begin
            state        <= state_next;
            ball         <= ball_next;
            move_cnt     <= move_cnt_next;
            period       <= period_next;
            game_over    <= game_over_next;
            you_win      <= you_win_next;
            send_trigger <= send_trigger_next;
            clear_done   <= clear_done_next;
        end
    end

    always_comb begin
        state_next        = state;
        ball_next         = ball;
        move_cnt_next     = move_cnt;
        period_next       = period;
        game_over_next    = 1'b0;
        you_win_next      = you_win;
        send_trigger_next = 1'b0;
        clear_done_next   = 1'b0;

        case (state)
            idle: begin
                ball_next     = serve_ball;
                period_next   = period_base;
                move_cnt_next = '0;
                if (slave_done && !you_win) begin
                    ball_next   = loaded_ball;
                    period_next = loaded_period;
                    state_next  = wait_link;
                end else if (game_start) begin
                    you_win_next = 1'b0;
                    state_next   = running_right;
                end
            end
            wait_link: begin
                clear_done_next = 1'b1;   // releases slave_done in the link
                state_next      = you_win ? idle : running_left;
            end
            win_flag: begin
                if (slave_done) begin
                    you_win_next = incoming.win;
                    if (!incoming.win) begin
                        ball_next     = loaded_ball;
                        period_next   = loaded_period;
                        move_cnt_next = '0;
                    end
                    state_next = wait_link;
                end
            end
            running_right: begin
                if (ball.x >= x_edge) begin
                    state_next        = send_ball;
                    send_trigger_next = 1'b1;   // snapshot taken on first send_ball cycle
                    move_cnt_next     = '0;
                end else if (move_due) begin
                    ball_next     = move_ball(ball, 1'b0, y_max);
                    move_cnt_next = '0;
                end else begin
                    move_cnt_next = move_cnt + 1'b1;
                end
            end
            running_left: begin
                if (collision) begin
                    state_next     = running_right;
                    move_cnt_next  = '0;
                    period_next    = pw'(STEP_BASE / int'(safe_speed));
                    ball_next.fast = (safe_speed == 10'd1);
                end else if (ball.x == 10'd0) begin
                    state_next = stop;
                end else if (move_due) begin
                    ball_next     = move_ball(ball, 1'b1, y_max);
                    move_cnt_next = '0;
                end else begin
                    move_cnt_next = move_cnt + 1'b1;
                end
            end
            stop: begin
                game_over_next = !game_start;
                if (game_start) begin
                    ball_next     = serve_ball;
                    period_next   = period_base;
                    move_cnt_next = '0;
                    state_next    = running_right;
                end
            end
            send_ball: begin
                if (master_done)
                    state_next = win_flag;
                else if (game_start)
                    state_next = idle;
            end
            default: state_next = idle;
        endcase
    end

endmodule

`default_nettype wire

// File: game/paddle_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module paddle_tracker
    import pong_pkg::*;
#(
    parameter int PADDLE_H      = 40,
    parameter int SAMPLE_CYCLES = 250000
) (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic [9:0]  paddle_y,
    input  ball_state_t ball,
    input  logic        moving_left,
    output logic        collision,
    output logic [9:0]  est_speed
);

    localparam int cw = $clog2(SAMPLE_CYCLES + 1);

    logic [cw-1:0] sample_cnt;
    logic [9:0]    prev_y;
    logic [9:0]    delta_y;
    logic [10:0]   paddle_bottom;
    logic          hit;

    assign paddle_bottom = {1'b0, paddle_y} + 11'(PADDLE_H);

    // ball at the left wall and inside the paddle span
    assign hit = moving_left
              && (ball.x <= step_x)
              && (ball.y >= paddle_y)
              && ({1'b0, ball.y} <= paddle_bottom);

    assign delta_y = (paddle_y >= prev_y) ? paddle_y - prev_y : prev_y - paddle_y;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            collision <= 1'b0;
        end else begin
            collision <= hit;
        end
    end

    // speed is pixels moved per sample window
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            sample_cnt <= '0;
            prev_y     <= '0;
            est_speed  <= '0;
        end else if (sample_cnt == cw'(SAMPLE_CYCLES - 1)) begin
            sample_cnt <= '0;
            prev_y     <= paddle_y;
            est_speed  <= delta_y;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: link/ball_link_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ball_link_regs
    import pong_pkg::*;
(
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  ball_state_t outgoing,
    input  logic        send_trigger,
    input  logic        clear_done,
    output handoff_t    incoming,
    output logic        slave_done,
    output logic        master_done,
    output logic        send_pending
);

    logic [9:0]  in_y;
    logic [7:0]  in_vy;
    logic [1:0]  in_grav;
    logic        in_fast;
    logic        in_win;
    logic [9:0]  out_y;
    logic [7:0]  out_vy;
    logic [1:0]  out_grav;
    logic        out_fast;
    logic        wr_fire, wr_byte, rd_fire;
    logic        commit_wr, ack_wr;
    logic [31:0] rd_word;

    // aw and w taken together, held off while a response is still out
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign wr_byte = wr_fire && wstrb[0];   // all registers live in byte 0
    assign bresp   = 2'b00;

    assign arready = !rvalid;
    assign rd_fire = arvalid && !rvalid;
    assign rresp   = 2'b00;

    assign commit_wr = wr_fire && (awaddr == addr_commit);
    assign ack_wr    = wr_fire && (awaddr == addr_ack);

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bvalid && bready)
                bvalid <= 1'b0;
            else if (wr_fire)
                bvalid <= 1'b1;
            if (rvalid && rready)
                rvalid <= 1'b0;
            else if (rd_fire)
                rvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (rd_fire)
            rdata <= rd_word;
    end

    // incoming ball from the partner
    always_ff @(posedge clk_25MHZ) begin
        if (wr_byte) begin
            case (awaddr)
                addr_in_y_hi:  in_y[9:8] <= wdata[7:6];
                addr_in_y_lo:  in_y[7:0] <= wdata[7:0];
                addr_in_vy:    in_vy     <= wdata[7:0];
                addr_in_grav:  in_grav   <= wdata[1:0];
                addr_in_speed: in_fast   <= wdata[0];
                addr_in_win:   in_win    <= wdata[0];
                default: ;   // read-only or unmapped, still answered OKAY
            endcase
        end
    end

    // outgoing snapshot for the partner to read
    always_ff @(posedge clk_25MHZ) begin
        if (send_trigger) begin
            out_y    <= outgoing.y;
            out_vy   <= outgoing.vy;
            out_grav <= outgoing.grav;
            out_fast <= outgoing.fast;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            slave_done   <= 1'b0;
            master_done  <= 1'b0;
            send_pending <= 1'b0;
        end else begin
            master_done <= ack_wr;   // single pulse
            if (commit_wr)
                slave_done <= 1'b1;
            else if (clear_done)
                slave_done <= 1'b0;
            if (send_trigger)
                send_pending <= 1'b1;
            else if (ack_wr)
                send_pending <= 1'b0;
        end
    end

    always_comb begin
        rd_word = '0;
        case (araddr)
            addr_in_y_hi:   rd_word[7:6] = in_y[9:8];
            addr_in_y_lo:   rd_word[7:0] = in_y[7:0];
            addr_in_vy:     rd_word[7:0] = in_vy;
            addr_in_grav:   rd_word[1:0] = in_grav;
            addr_in_speed:  rd_word[0]   = in_fast;
            addr_in_win:    rd_word[0]   = in_win;
            addr_commit:    rd_word[0]   = slave_done;
            addr_out_y_hi:  rd_word[7:6] = out_y[9:8];
            addr_out_y_lo:  rd_word[7:0] = out_y[7:0];
            addr_out_vy:    rd_word[7:0] = out_vy;
            addr_out_grav:  rd_word[1:0] = out_grav;
            addr_out_speed: rd_word[0]   = out_fast;
            addr_status:    rd_word[0]   = send_pending;
            default:        rd_word      = '0;
        endcase
    end

    always_comb begin
        incoming           = '0;   // x is set by the controller on entry
        incoming.ball.y    = in_y;
        incoming.ball.vy   = in_vy;
        incoming.ball.grav = in_grav;
        incoming.ball.fast = in_fast;
        incoming.win       = in_win;
    end

endmodule

`default_nettype wire

// File: design/pong_node_top.sv
`timescale 1ns/1ps
`default_nettype none

module pong_node_top
    import pong_pkg::*;
#(
    parameter int STEP_BASE     = 270000,
    parameter int PADDLE_H      = 40,
    parameter int SAMPLE_CYCLES = 250000
) (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic        game_start,
    input  logic [9:0]  paddle_y,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic [9:0]  ball_x,
    output logic [9:0]  ball_y,
    output logic        moving_left,
    output logic        moving_right,
    output logic        game_over,
    output logic        you_win,
    output logic        send_pending,
    output logic [7:0]  status_led
);

    ball_state_t ball;
    handoff_t    incoming;
    logic        collision;
    logic [9:0]  est_speed;
    logic        send_trigger, clear_done;
    logic        slave_done, master_done;

    assign ball_x = ball.x;
    assign ball_y = ball.y;

    game_controller #(
        .STEP_BASE(STEP_BASE)
    ) u_ctrl (
        .clk_25MHZ, .reset, .upscale, .game_start, .collision, .est_speed,
        .incoming, .slave_done, .master_done, .ball, .moving_left, .moving_right,
        .game_over, .you_win, .send_trigger, .clear_done, .status_led
    );

    paddle_tracker #(
        .PADDLE_H(PADDLE_H),
        .SAMPLE_CYCLES(SAMPLE_CYCLES)
    ) u_tracker (
        .clk_25MHZ, .reset, .paddle_y, .ball, .moving_left, .collision, .est_speed
    );

    ball_link_regs u_link (
        .clk_25MHZ, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .outgoing(ball), .send_trigger, .clear_done,
        .incoming, .slave_done, .master_done, .send_pending
    );

endmodule

`default_nettype wire

// File: sim/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// galois form with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);   // one step per bit
        v          = {v[30:0], lfsr_state[0]};
    end
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
endtask

task automatic report_failure(input string what);
    other_errors++;
    $display("Error at %0t ns: %s", $time, what);
endtask

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int   n;
    logic taken;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n     = 0;
    taken = 1'b0;
    while (!taken && n < 50) begin
        @(negedge clk_25MHZ);   // ready has settled mid-cycle
        taken = awready && wready;
        @(posedge clk_25MHZ);   // aw and w taken here when ready was seen
        #2;
        n++;
    end
    if (!taken)
        report_failure($sformatf("write to 0x%0h was never accepted", addr));
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < 50) begin
        @(posedge clk_25MHZ);
        #2;
        n++;
    end
    if (!bvalid)
        report_failure($sformatf("no write response for 0x%0h", addr));
    else
        check_value("bresp", bresp, 32'd0);
    @(posedge clk_25MHZ);
    #2;
    bready = 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    while (!arready && n < 50) begin
        @(posedge clk_25MHZ);
        #2;
        n++;
    end
    if (!arready)
        report_failure($sformatf("read of 0x%0h was never accepted", addr));
    @(posedge clk_25MHZ);
    #2;
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < 50) begin
        @(posedge clk_25MHZ);
        #2;
        n++;
    end
    data = rdata;
    if (!rvalid)
        report_failure($sformatf("no read data for 0x%0h", addr));
    else
        check_value("rresp", rresp, 32'd0);
    @(posedge clk_25MHZ);
    #2;
    rready = 1'b0;
endtask

`endif

// File: sim/tb_pong_node.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pong_node
    import pong_pkg::*;
();

    localparam int wait_limit = 4000;   // more cycles than one full crossing

    logic        clk_25MHZ, reset, upscale, game_start;
    logic [9:0]  paddle_y;
    logic [7:0]  awaddr, araddr;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [9:0]  ball_x, ball_y;
    logic        moving_left, moving_right, game_over, you_win, send_pending;
    logic [7:0]  status_led;

    logic [31:0] lfsr_state;
    int          checks, mismatches, other_errors, moves_checked;
    ball_state_t model;
    logic        tracking, track_left;
    logic [9:0]  last_x;

    `include "tb_axi_tasks.svh"

    pong_node_top #(
        .STEP_BASE(40),
        .PADDLE_H(40),
        .SAMPLE_CYCLES(16)
    ) DUT (.*);

    always #20 clk_25MHZ = ~clk_25MHZ;

    function automatic int y_limit();
        return upscale ? 479 : 239;
    endfunction

    // one ball move where y takes the old vy and a clamp flips vy
    function automatic ball_state_t ref_move(input ball_state_t b, input logic left,
                                             input int ymax);
        ball_state_t r;
        int          y, vy;
        r = b;
        if (left)
            r.x = (b.x > step_x) ? b.x - step_x : 10'd0;
        else
            r.x = b.x + step_x;
        vy = int'($signed(b.vy));
        y  = int'(b.y) + vy;
        if (b.grav == 2'd3)
            vy = vy + 1;
        r.grav = b.grav + 2'd1;
        if (y >= ymax) begin
            y  = ymax;
            vy = -vy;
        end else if (y <= 0) begin
            y  = 0;
            vy = -vy;
        end
        r.y  = 10'(y);
        r.vy = 8'(vy);
        return r;
    endfunction

    // y of the ball when it reaches the paddle column
    function automatic logic [9:0] predict_hit_y(input ball_state_t start);
        ball_state_t b;
        b = start;
        while (b.x > step_x)
            b = ref_move(b, 1'b1, y_limit());
        return b.y;
    endfunction

    function automatic logic probe(input string sig);
        case (sig)
            "send_pending": return send_pending;
            "moving_left":  return moving_left;
            "moving_right": return moving_right;
            "game_over":    return game_over;
            "you_win":      return you_win;
            "idle":         return status_led == (8'd1 << idle);
            default:        return 1'bx;
        endcase
    endfunction

    task automatic wait_for(input string sig, input logic val, input int limit);
        int n;
        n = 0;
        while (probe(sig) !== val && n < limit) begin
            @(posedge clk_25MHZ);
            #2;
            n++;
        end
        if (probe(sig) !== val)
            report_failure($sformatf("timed out waiting for %s to become %0b", sig, val));
    endtask

    // model steps whenever the ball moves
    always @(negedge clk_25MHZ) begin
        if (tracking && ball_x !== last_x) begin
            model = ref_move(model, track_left, y_limit());
            check_value("ball_x", ball_x, model.x);
            check_value("ball_y", ball_y, model.y);
            last_x = ball_x;
            moves_checked++;
        end
    end

    task automatic serve_new_ball();
        game_start = 1'b1;
        @(posedge clk_25MHZ);
        #2;
        game_start = 1'b0;
        wait_for("moving_right", 1'b1, 20);
        model      = '{x: 10'd0, y: serve_y, vy: -8'sd3, grav: 2'd0, fast: 1'b1};
        last_x     = 10'd0;
        track_left = 1'b0;
        tracking   = 1'b1;
    endtask

    task automatic send_incoming(input logic [9:0] y, input logic [7:0] vy, input logic win);
        axi_write(addr_in_y_hi, {24'd0, y[9:8], 6'd0});
        axi_write(addr_in_y_lo, {24'd0, y[7:0]});
        axi_write(addr_in_vy, {24'd0, vy});
        axi_write(addr_in_grav, 32'd0);
        axi_write(addr_in_speed, 32'd1);
        axi_write(addr_in_win, {31'd0, win});
        axi_write(addr_commit, 32'd1);
    endtask

    // partner reads the outgoing ball at the right edge and acknowledges
    task automatic hand_off_ball();
        logic [31:0] v;
        wait_for("send_pending", 1'b1, wait_limit);
        tracking = 1'b0;
        check_value("ball_x at edge", ball_x, (upscale ? 640 : 320) - edge_margin);
        axi_read(addr_out_y_hi, v);
        check_value("out_y_hi", v, {24'd0, model.y[9:8], 6'd0});
        axi_read(addr_out_y_lo, v);
        check_value("out_y_lo", v, {24'd0, model.y[7:0]});
        axi_read(addr_out_vy, v);
        check_value("out_vy", v, {24'd0, model.vy});
        axi_read(addr_out_grav, v);
        check_value("out_grav", v, {30'd0, model.grav});
        axi_read(addr_out_speed, v);
        check_value("out_speed", v, {31'd0, model.fast});
        axi_read(addr_status, v);
        check_value("status", v, 32'd1);
        axi_write(addr_ack, 32'd1);
        wait_for("send_pending", 1'b0, 20);
    endtask

    task automatic receive_ball(input logic [9:0] y, input logic [7:0] vy);
        logic [9:0] entry_x;
        entry_x = upscale ? return_x : 10'd320 - 10'd20;   // field width minus 20
        send_incoming(y, vy, 1'b0);
        wait_for("moving_left", 1'b1, 50);
        check_value("ball_x on entry", ball_x, entry_x);
        check_value("ball_y on entry", ball_y, y);
        model      = '{x: entry_x, y: y, vy: vy, grav: 2'd0, fast: 1'b1};
        last_x     = entry_x;
        track_left = 1'b1;
        tracking   = 1'b1;
    endtask

    initial begin
        logic [31:0] r;
        logic [9:0]  hit_y;
        clk_25MHZ = 1'b0;
        reset     = 1'b1;
        upscale   = 1'b1;
        game_start = 1'b0;
        paddle_y  = 10'd0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        lfsr_state = 32'he965;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        moves_checked = 0;
        tracking   = 1'b0;
        track_left = 1'b0;
        last_x     = '0;
        model      = '0;
        repeat (3) @(posedge clk_25MHZ);
        #2;
        reset = 1'b0;

        check_value("ball_x", ball_x, 32'd0);
        check_value("ball_y", ball_y, serve_y);
        check_value("moving_left", moving_left, 32'd0);
        check_value("moving_right", moving_right, 32'd0);
        check_value("game_over", game_over, 32'd0);
        check_value("you_win", you_win, 32'd0);
        check_value("send_pending", send_pending, 32'd0);
        check_value("status_led", status_led, 8'd1 << idle);

        serve_new_ball();
        hand_off_ball();

        // return with the paddle over the ball path
        rand_bits(9, r);
        hit_y = 10'(r % 480);
        rand_bits(4, r);
        receive_ball(hit_y, {{4{r[3]}}, r[3:0]});
        hit_y = predict_hit_y(model);
        rand_bits(5, r);
        paddle_y = (hit_y > r[4:0]) ? hit_y - r[4:0] : 10'd0;
        wait_for("moving_right", 1'b1, wait_limit);
        check_value("ball_x at paddle", ball_x, step_x);
        track_left = 1'b0;
        model.fast = 1'b1;   // a still paddle keeps the base period
        hand_off_ball();

        // paddle away from the path, ball runs out
        rand_bits(9, r);
        hit_y = 10'(r % 480);
        rand_bits(4, r);
        receive_ball(hit_y, {{4{r[3]}}, r[3:0]});
        hit_y = predict_hit_y(model);
        rand_bits(7, r);
        paddle_y = (hit_y < 10'd240) ? 10'd300 + r[6:0] : {3'd0, r[6:0]};
        wait_for("game_over", 1'b1, wait_limit);
        tracking = 1'b0;
        check_value("ball_x at game over", ball_x, 32'd0);
        check_value("moving_left", moving_left, 32'd0);

        upscale = 1'b0;
        serve_new_ball();
        hand_off_ball();

        send_incoming(serve_y, 8'd0, 1'b1);
        wait_for("you_win", 1'b1, 50);
        wait_for("idle", 1'b1, 20);
        check_value("you_win", you_win, 32'd1);
        check_value("moving_right", moving_right, 32'd0);

        if (moves_checked < 20)
            report_failure("too few ball moves were compared");
        $display("checks %0d, ball moves %0d, mismatches %0d, other errors %0d",
                 checks, moves_checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+sim
common/pong_pkg.sv
game/game_controller.sv
game/paddle_tracker.sv
link/ball_link_regs.sv
design/pong_node_top.sv
sim/tb_pong_node.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_pong_node
./obj_dir/Vtb_pong_node > sim.log
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
